/* rtl/ex_pkg.sv */
// Shared widths, operator codes and types of the execute stage, imported by every unit
`default_nettype none

package ex_pkg;

    // ------------------------------------------------------------------
    // Data path widths
    // ------------------------------------------------------------------
    localparam int unsigned XLEN          = 32;
    localparam int unsigned TRANS_ID_BITS = 3;
    localparam int unsigned SHAMT_BITS    = 5;
    localparam int unsigned CSR_ADDR_BITS = 12;

    typedef logic [XLEN-1:0]          xlen_t;
    typedef logic [TRANS_ID_BITS-1:0] trans_id_t;
    typedef logic [CSR_ADDR_BITS-1:0] csr_addr_t;

    // ------------------------------------------------------------------
    // Operator encoding on the issue port
    // ------------------------------------------------------------------
    typedef logic [3:0] op_t;

    // ALU operations
    localparam op_t OP_ADD   = 4'd0;
    localparam op_t OP_SUB   = 4'd1;
    localparam op_t OP_AND   = 4'd2;
    localparam op_t OP_OR    = 4'd3;
    localparam op_t OP_XOR   = 4'd4;
    localparam op_t OP_SLL   = 4'd5;
    localparam op_t OP_SRL   = 4'd6;
    localparam op_t OP_SLT   = 4'd7;

    // Branches and jumps, compare done in the ALU
    localparam op_t OP_BEQ   = 4'd8;
    localparam op_t OP_BNE   = 4'd9;
    localparam op_t OP_BLT   = 4'd10;
    localparam op_t OP_JALR  = 4'd11;

    // Multiplier
    localparam op_t OP_MUL   = 4'd12;
    localparam op_t OP_MULH  = 4'd13;

    // CSR access, value refetched at commit
    localparam op_t OP_CSRRW = 4'd14;

endpackage

`default_nettype wire

/* rtl/fu_decode.sv */
// Operand silencing and operator decode in front of the fixed-latency units
`timescale 1ns/10ps
`default_nettype none

module fu_decode (
    input  ex_pkg::op_t       fu_op_i,
    input  ex_pkg::xlen_t     operand_a_i,
    input  ex_pkg::xlen_t     operand_b_i,
    input  ex_pkg::xlen_t     imm_i,
    input  logic              alu_valid_i,
    input  logic              branch_valid_i,
    input  logic              mult_valid_i,
    input  logic              csr_valid_i,
    output ex_pkg::xlen_t     alu_a_o,
    output ex_pkg::xlen_t     alu_b_o,
    output ex_pkg::xlen_t     mult_a_o,
    output ex_pkg::xlen_t     mult_b_o,
    output logic              mult_high_o,
    output ex_pkg::xlen_t     csr_wdata_o,
    output ex_pkg::csr_addr_t csr_addr_o
);
    import ex_pkg::*;

    logic alu_sel;

    // Branches borrow the ALU for their compare
    assign alu_sel = alu_valid_i | branch_valid_i;

    assign alu_a_o = alu_sel ? operand_a_i : '0;
    assign alu_b_o = alu_sel ? operand_b_i : '0;

    // Multiplier inputs stay quiet unless a multiply issues
    assign mult_a_o    = mult_valid_i ? operand_a_i : '0;
    assign mult_b_o    = mult_valid_i ? operand_b_i : '0;
    assign mult_high_o = mult_valid_i && (fu_op_i == OP_MULH);

    // CSR address sits in the low immediate bits
    assign csr_wdata_o = csr_valid_i ? operand_a_i : '0;
    assign csr_addr_o  = csr_valid_i ? imm_i[CSR_ADDR_BITS-1:0] : '0;

endmodule

`default_nettype wire

/* rtl/alu.sv */
// Single-cycle ALU of the execute stage, also producing the branch compare result
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  ex_pkg::op_t   fu_op_i,
    input  ex_pkg::xlen_t a_i,
    input  ex_pkg::xlen_t b_i,
    output ex_pkg::xlen_t result_o,
    output logic          branch_cond_o
);
    import ex_pkg::*;

    logic [SHAMT_BITS-1:0] shamt;
    logic                  less_signed;
    logic                  equal;

    assign shamt       = b_i[SHAMT_BITS-1:0];
    assign less_signed = $signed(a_i) < $signed(b_i);
    assign equal       = (a_i == b_i);

    // ------------------------------------------------------------------
    // Arithmetic, logic and shifts
    // ------------------------------------------------------------------
    always_comb begin
        result_o = '0;
        unique case (fu_op_i)
            OP_ADD:  result_o = a_i + b_i;
            OP_SUB:  result_o = a_i - b_i;
            OP_AND:  result_o = a_i & b_i;
            OP_OR:   result_o = a_i | b_i;
            OP_XOR:  result_o = a_i ^ b_i;
            OP_SLL:  result_o = a_i << shamt;
            OP_SRL:  result_o = a_i >> shamt;
            OP_SLT:  result_o = {{(XLEN-1){1'b0}}, less_signed};
            default: result_o = '0;
        endcase
    end

    // ------------------------------------------------------------------
    // Branch condition
    // ------------------------------------------------------------------
    always_comb begin
        branch_cond_o = 1'b0;
        unique case (fu_op_i)
            OP_BEQ:  branch_cond_o = equal;
            OP_BNE:  branch_cond_o = ~equal;
            OP_BLT:  branch_cond_o = less_signed;
            // Jumps are always taken
            OP_JALR: branch_cond_o = 1'b1;
            default: branch_cond_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/branch_unit.sv */
// Branch and JALR resolution against the front-end prediction, same cycle as issue
`timescale 1ns/10ps
`default_nettype none

module branch_unit #(
    parameter bit RVC = 1'b1
) (
    input  logic          branch_valid_i,
    input  ex_pkg::op_t   fu_op_i,
    input  ex_pkg::xlen_t operand_a_i,
    input  ex_pkg::xlen_t imm_i,
    input  ex_pkg::xlen_t pc_i,
    input  logic          is_compressed_i,
    input  logic          branch_cond_i,
    input  logic          predict_taken_i,
    input  ex_pkg::xlen_t predict_target_i,
    output ex_pkg::xlen_t link_o,
    output logic          resolve_o,
    output logic          taken_o,
    output ex_pkg::xlen_t target_o,
    output logic          mispredict_o,
    output logic          exception_o,
    output ex_pkg::xlen_t tval_o
);
    import ex_pkg::*;

    xlen_t jump_base;
    xlen_t jump_sum;
    xlen_t jump_target;
    logic  is_jalr;

    assign is_jalr = (fu_op_i == OP_JALR);

    // JALR is register relative, conditional branches are PC relative
    assign jump_base   = is_jalr ? operand_a_i : pc_i;
    assign jump_sum    = jump_base + imm_i;
    assign jump_target = is_jalr ? {jump_sum[XLEN-1:1], 1'b0} : jump_sum;

    // Fall-through doubles as the link address
    assign link_o = pc_i + (is_compressed_i ? xlen_t'(2) : xlen_t'(4));

    assign resolve_o = branch_valid_i;
    assign taken_o   = branch_valid_i & branch_cond_i;
    assign target_o  = taken_o ? jump_target : link_o;

    // Wrong direction, or right direction with a stale target
    assign mispredict_o = branch_valid_i &
                          ((predict_taken_i != taken_o) ||
                           (taken_o && (predict_target_i != jump_target)));

    // Without compressed support targets must be word aligned
    assign exception_o = branch_valid_i && taken_o && !RVC && jump_target[1];
    assign tval_o      = jump_target;

endmodule

`default_nettype wire

/* rtl/csr_buffer.sv */
// One-deep CSR address buffer that stalls issue until the CSR access commits
`timescale 1ns/10ps
`default_nettype none

module csr_buffer (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  logic              csr_valid_i,
    input  logic              csr_commit_i,
    input  ex_pkg::csr_addr_t addr_i,
    input  ex_pkg::xlen_t     wdata_i,
    output logic              ready_o,
    output ex_pkg::xlen_t     result_o,
    output ex_pkg::csr_addr_t csr_addr_o
);
    import ex_pkg::*;

    typedef enum logic {
        CSR_EMPTY,
        CSR_FULL
    } csr_state_e;

    csr_state_e state_q;
    csr_addr_t  addr_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= CSR_EMPTY;
            addr_q  <= '0;
        end else if (flush_i) begin
            state_q <= CSR_EMPTY;
        end else begin
            unique case (state_q)
                CSR_EMPTY: begin
                    if (csr_valid_i) begin
                        state_q <= CSR_FULL;
                        addr_q  <= addr_i;
                    end
                end
                // Wait for the instruction to retire
                CSR_FULL: if (csr_commit_i) state_q <= CSR_EMPTY;
                default:  state_q <= CSR_EMPTY;
            endcase
        end
    end

    assign ready_o    = (state_q == CSR_EMPTY);
    assign csr_addr_o = addr_q;
    // Write-back carries rs1, the CSR file does the real access at commit
    assign result_o   = wdata_i;

endmodule

`default_nettype wire

/* rtl/mult.sv */
// Signed 32-bit multiplier with a single register stage and its own transaction ID
`timescale 1ns/10ps
`default_nettype none

module mult (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  logic              valid_i,
    input  ex_pkg::xlen_t     a_i,
    input  ex_pkg::xlen_t     b_i,
    input  logic              high_i,
    input  ex_pkg::trans_id_t trans_id_i,
    output logic              valid_o,
    output ex_pkg::xlen_t     result_o,
    output ex_pkg::trans_id_t trans_id_o
);
    import ex_pkg::*;

    logic signed [2*XLEN-1:0] product;
    logic                     valid_q;

    // Operands sign extended to the full product width
    assign product = $signed({{XLEN{a_i[XLEN-1]}}, a_i}) *
                     $signed({{XLEN{b_i[XLEN-1]}}, b_i});

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i & ~flush_i;
        end
    end

    // Result and ID only move when a multiply issues
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            result_o   <= high_i ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];
            trans_id_o <= trans_id_i;
        end
    end

    // A flush in the write-back cycle still kills the product
    assign valid_o = valid_q & ~flush_i;

endmodule

`default_nettype wire

/* rtl/flu_result.sv */
// Merges the fixed-latency unit results onto the single write-back port
`timescale 1ns/10ps
`default_nettype none

module flu_result (
    input  logic              alu_valid_i,
    input  logic              branch_valid_i,
    input  logic              csr_valid_i,
    input  logic              csr_ready_i,
    input  ex_pkg::xlen_t     alu_result_i,
    input  ex_pkg::xlen_t     link_i,
    input  ex_pkg::xlen_t     csr_result_i,
    input  logic              mult_valid_i,
    input  ex_pkg::xlen_t     mult_result_i,
    input  ex_pkg::trans_id_t mult_trans_id_i,
    input  ex_pkg::trans_id_t trans_id_i,
    output ex_pkg::xlen_t     flu_result_o,
    output ex_pkg::trans_id_t flu_trans_id_o,
    output logic              flu_valid_o,
    output logic              flu_ready_o
);

    always_comb begin
        // Branch link when nothing else claims the port
        flu_result_o   = link_i;
        flu_trans_id_o = trans_id_i;
        if (alu_valid_i) begin
            flu_result_o = alu_result_i;
        end else if (csr_valid_i) begin
            flu_result_o = csr_result_i;
        end else if (mult_valid_i) begin
            flu_result_o   = mult_result_i;
            flu_trans_id_o = mult_trans_id_i;
        end
    end

    assign flu_valid_o = alu_valid_i | branch_valid_i | csr_valid_i | mult_valid_i;
    // Only the CSR buffer can stall issue
    assign flu_ready_o = csr_ready_i;

endmodule

`default_nettype wire

/* rtl/ex_stage.sv */
// Top level of the fixed-latency execute stage: decode, ALU, branch, CSR, multiplier, write-back
`timescale 1ns/10ps
`default_nettype none

module ex_stage #(
    parameter bit RVC = 1'b1
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    // Issue port
    input  ex_pkg::op_t       fu_op_i,
    input  ex_pkg::xlen_t     operand_a_i,
    input  ex_pkg::xlen_t     operand_b_i,
    input  ex_pkg::xlen_t     imm_i,
    input  ex_pkg::xlen_t     pc_i,
    input  logic              is_compressed_i,
    input  ex_pkg::trans_id_t trans_id_i,
    input  logic              predict_taken_i,
    input  ex_pkg::xlen_t     predict_target_i,
    input  logic              alu_valid_i,
    input  logic              branch_valid_i,
    input  logic              csr_valid_i,
    input  logic              mult_valid_i,
    input  logic              csr_commit_i,
    // Write-back port
    output ex_pkg::xlen_t     flu_result_o,
    output ex_pkg::trans_id_t flu_trans_id_o,
    output logic              flu_valid_o,
    output logic              flu_ready_o,
    output logic              flu_exception_o,
    output ex_pkg::xlen_t     flu_tval_o,
    // Branch resolution
    output logic              resolve_branch_o,
    output logic              resolved_taken_o,
    output ex_pkg::xlen_t     resolved_target_o,
    output logic              mispredict_o,
    // CSR address towards the CSR file
    output ex_pkg::csr_addr_t csr_addr_o
);
    import ex_pkg::*;

    xlen_t     alu_a, alu_b, alu_result;
    xlen_t     mult_a, mult_b, mult_result;
    xlen_t     csr_wdata, csr_result, link;
    csr_addr_t csr_addr_dec;
    trans_id_t mult_trans_id;
    logic      mult_high, mult_valid;
    logic      branch_cond, csr_ready;

    // ------------------------------------------------------------------
    // Decode and operand silencing
    // ------------------------------------------------------------------
    fu_decode i_fu_decode (
        .fu_op_i        ( fu_op_i        ),
        .operand_a_i    ( operand_a_i    ),
        .operand_b_i    ( operand_b_i    ),
        .imm_i          ( imm_i          ),
        .alu_valid_i    ( alu_valid_i    ),
        .branch_valid_i ( branch_valid_i ),
        .mult_valid_i   ( mult_valid_i   ),
        .csr_valid_i    ( csr_valid_i    ),
        .alu_a_o        ( alu_a          ),
        .alu_b_o        ( alu_b          ),
        .mult_a_o       ( mult_a         ),
        .mult_b_o       ( mult_b         ),
        .mult_high_o    ( mult_high      ),
        .csr_wdata_o    ( csr_wdata      ),
        .csr_addr_o     ( csr_addr_dec   )
    );

    // ------------------------------------------------------------------
    // Units
    // ------------------------------------------------------------------
    alu i_alu (
        .fu_op_i       ( fu_op_i     ),
        .a_i           ( alu_a       ),
        .b_i           ( alu_b       ),
        .result_o      ( alu_result  ),
        .branch_cond_o ( branch_cond )
    );

    // Operands not silenced here, the target adder is timing critical
    branch_unit #(
        .RVC ( RVC )
    ) i_branch_unit (
        .branch_valid_i   ( branch_valid_i    ),
        .fu_op_i          ( fu_op_i           ),
        .operand_a_i      ( operand_a_i       ),
        .imm_i            ( imm_i             ),
        .pc_i             ( pc_i              ),
        .is_compressed_i  ( is_compressed_i   ),
        .branch_cond_i    ( branch_cond       ),
        .predict_taken_i  ( predict_taken_i   ),
        .predict_target_i ( predict_target_i  ),
        .link_o           ( link              ),
        .resolve_o        ( resolve_branch_o  ),
        .taken_o          ( resolved_taken_o  ),
        .target_o         ( resolved_target_o ),
        .mispredict_o     ( mispredict_o      ),
        .exception_o      ( flu_exception_o   ),
        .tval_o           ( flu_tval_o        )
    );

    csr_buffer i_csr_buffer (
        .clk_i        ( clk_i        ),
        .rst_ni       ( rst_ni       ),
        .flush_i      ( flush_i      ),
        .csr_valid_i  ( csr_valid_i  ),
        .csr_commit_i ( csr_commit_i ),
        .addr_i       ( csr_addr_dec ),
        .wdata_i      ( csr_wdata    ),
        .ready_o      ( csr_ready    ),
        .result_o     ( csr_result   ),
        .csr_addr_o   ( csr_addr_o   )
    );

    mult i_mult (
        .clk_i      ( clk_i         ),
        .rst_ni     ( rst_ni        ),
        .flush_i    ( flush_i       ),
        .valid_i    ( mult_valid_i  ),
        .a_i        ( mult_a        ),
        .b_i        ( mult_b        ),
        .high_i     ( mult_high     ),
        .trans_id_i ( trans_id_i    ),
        .valid_o    ( mult_valid    ),
        .result_o   ( mult_result   ),
        .trans_id_o ( mult_trans_id )
    );

    // ------------------------------------------------------------------
    // Write-back
    // ------------------------------------------------------------------
    flu_result i_flu_result (
        .alu_valid_i     ( alu_valid_i    ),
        .branch_valid_i  ( branch_valid_i ),
        .csr_valid_i     ( csr_valid_i    ),
        .csr_ready_i     ( csr_ready      ),
        .alu_result_i    ( alu_result     ),
        .link_i          ( link           ),
        .csr_result_i    ( csr_result     ),
        .mult_valid_i    ( mult_valid     ),
        .mult_result_i   ( mult_result    ),
        .mult_trans_id_i ( mult_trans_id  ),
        .trans_id_i      ( trans_id_i     ),
        .flu_result_o    ( flu_result_o   ),
        .flu_trans_id_o  ( flu_trans_id_o ),
        .flu_valid_o     ( flu_valid_o    ),
        .flu_ready_o     ( flu_ready_o    )
    );

endmodule

`default_nettype wire

/* tests/ex_stage_sva.sv */
// Latency and stall assertions on the execute stage, bound into every ex_stage instance
`timescale 1ns/10ps
`default_nettype none

module ex_stage_sva (
    input logic clk_i,
    input logic rst_ni,
    input logic flush_i,
    input logic mult_valid_i,
    input logic csr_valid_i,
    input logic flu_valid_i,
    input logic flu_ready_i
);

    // Multiply result owns the write port one cycle later unless flushed
    mult_latency_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mult_valid_i && !flush_i) |=> (flush_i || flu_valid_i))
        else $error("multiply result missing one cycle after issue");

    // CSR issue stalls the stage from the next cycle
    csr_stall_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (csr_valid_i && !flush_i) |=> !flu_ready_i)
        else $error("flu_ready_o still high in the cycle after a CSR issue");

endmodule

bind ex_stage ex_stage_sva i_ex_stage_sva (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .flush_i      ( flush_i      ),
    .mult_valid_i ( mult_valid_i ),
    .csr_valid_i  ( csr_valid_i  ),
    .flu_valid_i  ( flu_valid_o  ),
    .flu_ready_i  ( flu_ready_o  )
);

`default_nettype wire

/* tests/tb_ex_stage.sv */
// Testbench for the execute stage, replays the stimulus file one issue per cycle and checks outputs
`timescale 1ns/10ps
`default_nettype none

module tb_ex_stage;
    import ex_pkg::*;

    localparam int CLK_PERIOD = 40;

    logic      clk_i, rst_ni, flush_i, csr_commit_i;
    op_t       fu_op_i;
    xlen_t     operand_a_i, operand_b_i, imm_i, pc_i, predict_target_i;
    logic      is_compressed_i, predict_taken_i;
    trans_id_t trans_id_i;
    logic      alu_valid_i, branch_valid_i, csr_valid_i, mult_valid_i;
    xlen_t     flu_result_o, flu_tval_o, resolved_target_o;
    trans_id_t flu_trans_id_o;
    logic      flu_valid_o, flu_ready_o, flu_exception_o;
    logic      resolve_branch_o, resolved_taken_o, mispredict_o;
    csr_addr_t csr_addr_o;

    string       lines[$];
    string       name, unit;
    logic [31:0] op_v, a_v, b_v, imm_v, pc_v, c_v, tid_v, pt_v, ptgt_v, flush_v, commit_v;
    logic [31:0] e_valid, e_result, e_tid, e_ready, e_resolve, e_taken, e_target;
    logic [31:0] e_mp, e_exc, e_tval, e_csr;
    logic        parsed;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          limit = 0;

    ex_stage #(
        .RVC ( 1'b0 )
    ) i_ex_stage (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // Watchdog, limit is set once the stimulus length is known
    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout after %0d cycles, the stimulus did not finish", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic compare_value(input string test, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("mismatch %s %s: expected %h, actual %h", test, field, expected, actual);
        end
    endtask

    task automatic clear_inputs;
        flush_i          = 1'b0;
        csr_commit_i     = 1'b0;
        fu_op_i          = '0;
        operand_a_i      = '0;
        operand_b_i      = '0;
        imm_i            = '0;
        pc_i             = '0;
        predict_target_i = '0;
        is_compressed_i  = 1'b0;
        predict_taken_i  = 1'b0;
        trans_id_i       = '0;
        alu_valid_i      = 1'b0;
        branch_valid_i   = 1'b0;
        csr_valid_i      = 1'b0;
        mult_valid_i     = 1'b0;
    endtask

    task automatic load_stimulus;
        int    fd;
        string text;
        fd = $fopen("tests/ex_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open tests/ex_stimulus.txt, no stimulus was applied");
        end else begin
            while (!$feof(fd)) begin
                text = "";
                void'($fgets(text, fd));
                // Skip blank lines and column notes
                if (text.len() > 1 && text.getc(0) != "#") lines.push_back(text);
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_line(input int idx);
        int count;
        count = $sscanf(lines[idx],
            "%s %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            name, unit, op_v, a_v, b_v, imm_v, pc_v, c_v, tid_v, pt_v, ptgt_v, flush_v,
            commit_v, e_valid, e_result, e_tid, e_ready, e_resolve, e_taken, e_target,
            e_mp, e_exc, e_tval, e_csr);
        clear_inputs();
        parsed = (count == 24);
        if (!parsed) begin
            errors++;
            $display("Stimulus line %0d is malformed, %0d of 24 fields read", idx, count);
        end else begin
            fu_op_i          = op_v[3:0];
            operand_a_i      = a_v;
            operand_b_i      = b_v;
            imm_i            = imm_v;
            pc_i             = pc_v;
            is_compressed_i  = c_v[0];
            trans_id_i       = tid_v[2:0];
            predict_taken_i  = pt_v[0];
            predict_target_i = ptgt_v;
            flush_i          = flush_v[0];
            csr_commit_i     = commit_v[0];
            alu_valid_i      = (unit == "alu");
            branch_valid_i   = (unit == "br");
            csr_valid_i      = (unit == "csr");
            mult_valid_i     = (unit == "mul");
            if (unit != "alu" && unit != "br" && unit != "csr" && unit != "mul" &&
                unit != "nop") begin
                errors++;
                $display("Test %s names an unknown unit %s", name, unit);
            end
        end
    endtask

    task automatic check_outputs;
        compare_value(name, "flu_valid", e_valid, 32'(flu_valid_o));
        if (e_valid[0]) begin
            compare_value(name, "flu_result", e_result, flu_result_o);
            compare_value(name, "flu_trans_id", e_tid, 32'(flu_trans_id_o));
        end
        compare_value(name, "flu_ready", e_ready, 32'(flu_ready_o));
        compare_value(name, "resolve_branch", e_resolve, 32'(resolve_branch_o));
        compare_value(name, "resolved_taken", e_taken, 32'(resolved_taken_o));
        if (e_resolve[0]) compare_value(name, "resolved_target", e_target, resolved_target_o);
        compare_value(name, "mispredict", e_mp, 32'(mispredict_o));
        compare_value(name, "flu_exception", e_exc, 32'(flu_exception_o));
        if (e_exc[0]) compare_value(name, "flu_tval", e_tval, flu_tval_o);
        compare_value(name, "csr_addr", e_csr, 32'(csr_addr_o));
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        clk_i  = 1'b0;
        rst_ni = 1'b0;
        clear_inputs();
        load_stimulus();
        limit = lines.size() * 4 + 50;
        repeat (4) @(negedge clk_i);
        rst_ni = 1'b1;
        #(CLK_PERIOD / 4);
        compare_value("after_reset", "flu_valid", 32'd0, 32'(flu_valid_o));
        compare_value("after_reset", "resolve_branch", 32'd0, 32'(resolve_branch_o));
        compare_value("after_reset", "flu_ready", 32'd1, 32'(flu_ready_o));
        foreach (lines[i]) begin
            @(negedge clk_i);
            apply_line(i);
            // Sample a quarter period later, well away from both edges
            #(CLK_PERIOD / 4);
            if (parsed) check_outputs();
        end
        @(negedge clk_i);
        clear_inputs();
        @(negedge clk_i);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/ex_stimulus.txt */
# name unit op a b imm pc compressed trans_id pred_taken pred_target flush commit, all hex
# then expected: valid result trans_id ready resolve taken target mispredict exc tval csr_addr
add          alu 0 5 7 0 0 0 1 0 0 0 0                 1 c 1 1 0 0 0 0 0 0 0
sub_wrap     alu 1 1 2 0 0 0 2 0 0 0 0                 1 ffffffff 2 1 0 0 0 0 0 0 0
slt_signed   alu 7 ffffffff 1 0 0 0 3 0 0 0 0          1 1 3 1 0 0 0 0 0 0 0
sll_5bit     alu 5 1 24 0 0 0 4 0 0 0 0                1 10 4 1 0 0 0 0 0 0 0
srl_5bit     alu 6 80000000 3f 0 0 0 5 0 0 0 0         1 1 5 1 0 0 0 0 0 0 0
xor_mask     alu 4 ff00ff00 0ff00ff0 0 0 0 6 0 0 0 0   1 f0f0f0f0 6 1 0 0 0 0 0 0 0
beq_taken    br 8 10 10 100 1000 0 7 1 1100 0 0        1 1004 7 1 1 1 1100 0 0 0 0
beq_not      br 8 1 2 10 1200 0 5 0 0 0 0              1 1204 5 1 1 0 1204 0 0 0 0
bne_not      br 9 5 5 40 2000 1 0 1 2040 0 0           1 2002 0 1 1 0 2002 1 0 0 0
bne_taken    br 9 1 2 fffffff8 1300 1 6 0 0 0 0        1 1302 6 1 1 1 12f8 1 0 0 0
blt_taken    br a fffffff0 3 ffffffe0 3000 0 1 1 2fe4 0 0  1 3004 1 1 1 1 2fe0 1 0 0 0
blt_not      br a 3 fffffff0 8 3100 0 2 0 0 0 0        1 3104 2 1 1 0 3104 0 0 0 0
jalr         br b 4000 0 21 500 0 3 1 4020 0 0         1 504 3 1 1 1 4020 0 0 0 0
jalr_misalgn br b 4000 0 6 600 1 4 1 4006 0 0          1 602 4 1 1 1 4006 0 1 4006 0
mul          mul c fffffffd 7 0 0 0 5 0 0 0 0          0 0 0 1 0 0 0 0 0 0 0
mulh         mul d 80000000 3 0 0 0 6 0 0 0 0          1 ffffffeb 5 1 0 0 0 0 0 0 0
mulh_out     nop 0 0 0 0 0 0 0 0 0 0 0                 1 fffffffe 6 1 0 0 0 0 0 0 0
mul_flushed  mul c 6 7 0 0 0 7 0 0 0 0                 0 0 0 1 0 0 0 0 0 0 0
flush_mul    nop 0 0 0 0 0 0 0 0 0 1 0                 0 0 0 1 0 0 0 0 0 0 0
after_flush  nop 0 0 0 0 0 0 0 0 0 0 0                 0 0 0 1 0 0 0 0 0 0 0
csr_write    csr e deadbeef 0 305 0 0 1 0 0 0 0        1 deadbeef 1 1 0 0 0 0 0 0 0
csr_held     nop 0 0 0 0 0 0 0 0 0 0 0                 0 0 0 0 0 0 0 0 0 0 305
csr_commit   nop 0 0 0 0 0 0 0 0 0 0 1                 0 0 0 0 0 0 0 0 0 0 305
csr_done     nop 0 0 0 0 0 0 0 0 0 0 0                 0 0 0 1 0 0 0 0 0 0 305
csr_again    csr e 12345678 0 fffff340 0 0 2 0 0 0 0   1 12345678 2 1 0 0 0 0 0 0 305
csr_flushed  nop 0 0 0 0 0 0 0 0 0 1 0                 0 0 0 0 0 0 0 0 0 0 340
csr_restored nop 0 0 0 0 0 0 0 0 0 0 0                 0 0 0 1 0 0 0 0 0 0 340

/* tb.f */
rtl/ex_pkg.sv
rtl/fu_decode.sv
rtl/alu.sv
rtl/branch_unit.sv
rtl/csr_buffer.sv
rtl/mult.sv
rtl/flu_result.sv
rtl/ex_stage.sv
tests/ex_stage_sva.sv
tests/tb_ex_stage.sv

/* Makefile */
TOP = tb_ex_stage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
